// ==== hw/prci_bus_pkg.sv ====
// APB bus types
package prci_bus_pkg;

  // Byte address within the controller's APB window
  typedef logic [7:0] apb_addr_t;

  // Data word of the bus
  typedef logic [31:0] apb_data_t;

  // Request from the APB master, 43 bits
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_in_t;

  // Response to the master, 33 bits
  // Zero wait states, so there is no ready field
  typedef struct packed {
    apb_data_t prdata;
    logic      pslverr;
  } apb_out_t;

endpackage

// ==== hw/prci_cfg_pkg.sv ====
// Reset controller configuration
package prci_cfg_pkg;

  // Register map
  localparam prci_bus_pkg::apb_addr_t ADDR_STATUS = 8'h00;
  localparam prci_bus_pkg::apb_addr_t ADDR_CTRL   = 8'h04;
  localparam prci_bus_pkg::apb_addr_t ADDR_RSTCNT = 8'h08;

  // Sequencer states
  // ST_HOLD spans both the hold count and the wait for DDR calibration
  typedef enum logic [1:0] {
    ST_RESET    = 2'd0,
    ST_WAIT_PLL = 2'd1,
    ST_HOLD     = 2'd2,
    ST_RUN      = 2'd3
  } seq_state_t;

  // Filtered lock levels
  // Packed so that STATUS bits 1:0 read as {sys, ddr}
  typedef struct packed {
    logic sys_locked;
    logic ddr_locked;
  } lock_status_t;

  // Number of system reset events seen since power-up or the last clear
  typedef logic [15:0] rst_cnt_t;

endpackage

// ==== hw/prci_lock_filter.sv ====
// Lock synchronizer and filter
`timescale 1ns/1ps

module prci_lock_filter #(
  parameter int FILTER_CYCLES = 4
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_sys_locked,
  input  logic                       i_ddr_locked,
  output prci_cfg_pkg::lock_status_t o_locks
);

  localparam int CNT_W = $clog2(FILTER_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FILTER_CYCLES);

  logic [1:0] w_raw;
  logic [1:0] r_sync1;
  logic [1:0] r_sync2;
  logic [1:0] w_filt;

  // Bit 1 is the PLL lock, bit 0 the DDR calibration flag
  assign w_raw = {i_sys_locked, i_ddr_locked};

  // Two-flop synchronizers for both levels
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_sync1 <= '0;
      r_sync2 <= '0;
    end else begin
      r_sync1 <= w_raw;
      r_sync2 <= r_sync1;
    end
  end

  for (genvar g = 0; g < 2; g++) begin : g_lock
    logic [CNT_W-1:0] r_cnt;

    // Counts consecutive high samples and saturates when full
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        r_cnt <= '0;
      end else if (!r_sync2[g]) begin
        r_cnt <= '0;
      end else if (r_cnt != CNT_FULL) begin
        r_cnt <= r_cnt + 1'b1;
      end
    end

    // Falls with the synchronized level, rises only once the count is full
    assign w_filt[g] = r_sync2[g] && (r_cnt == CNT_FULL);
  end

  assign o_locks = prci_cfg_pkg::lock_status_t'(w_filt);

endmodule

// ==== hw/prci_hold_timer.sv ====
// Reset hold timer
`timescale 1ns/1ps

module prci_hold_timer #(
  parameter int HOLD_CYCLES = 8
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_start,
  output logic o_done
);

  localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

  logic [CNT_W-1:0] r_cnt;
  logic             r_done;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_cnt  <= '0;
      r_done <= 1'b0;
    end else if (i_start) begin
      // Restart, even in the middle of a count
      r_cnt  <= CNT_W'(HOLD_CYCLES);
      r_done <= 1'b0;
    end else if (r_cnt != '0) begin
      r_cnt <= r_cnt - 1'b1;
      // Done goes high on the edge where the count reaches zero
      if (r_cnt == CNT_W'(1)) begin
        r_done <= 1'b1;
      end
    end
  end

  // Held until the next start
  assign o_done = r_done;

endmodule

// ==== hw/prci_reset_seq.sv ====
// Reset sequencer
`timescale 1ns/1ps

module prci_reset_seq (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  prci_cfg_pkg::lock_status_t i_locks,
  input  logic                       i_timer_done,
  input  logic                       i_soft_rst,
  input  logic                       i_dmireset,
  output logic                       o_timer_start,
  output logic                       o_rst_event,
  output prci_cfg_pkg::seq_state_t   o_state,
  output logic                       o_sys_nrst,
  output logic                       o_dbg_nrst
);

  prci_cfg_pkg::seq_state_t r_state;

  logic w_hold_done;
  logic w_sw_rst;

  // Timer still shows the last run's done while the start pulse is in flight
  assign w_hold_done = i_timer_done && !o_timer_start;

  // Software and debug module requests act the same way
  assign w_sw_rst = i_soft_rst || i_dmireset;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state       <= prci_cfg_pkg::ST_RESET;
      o_timer_start <= 1'b0;
      o_rst_event   <= 1'b0;
      o_sys_nrst    <= 1'b0;
      o_dbg_nrst    <= 1'b0;
    end else begin
      // Pulses are low unless a branch below raises them
      o_timer_start <= 1'b0;
      o_rst_event   <= 1'b0;

      case (r_state)
        prci_cfg_pkg::ST_RESET: begin
          r_state <= prci_cfg_pkg::ST_WAIT_PLL;
        end

        prci_cfg_pkg::ST_WAIT_PLL: begin
          o_sys_nrst <= 1'b0;
          o_dbg_nrst <= 1'b0;
          if (i_locks.sys_locked) begin
            o_timer_start <= 1'b1;
            r_state       <= prci_cfg_pkg::ST_HOLD;
          end
        end

        prci_cfg_pkg::ST_HOLD: begin
          if (!i_locks.sys_locked) begin
            o_sys_nrst <= 1'b0;
            o_dbg_nrst <= 1'b0;
            r_state    <= prci_cfg_pkg::ST_WAIT_PLL;
          end else if (w_hold_done) begin
            // Debug side comes out first, system side waits for DDR
            o_dbg_nrst <= 1'b1;
            if (i_locks.ddr_locked) begin
              o_sys_nrst <= 1'b1;
              r_state    <= prci_cfg_pkg::ST_RUN;
            end
          end
        end

        prci_cfg_pkg::ST_RUN: begin
          if (!i_locks.sys_locked) begin
            o_sys_nrst  <= 1'b0;
            o_dbg_nrst  <= 1'b0;
            o_rst_event <= 1'b1;
            r_state     <= prci_cfg_pkg::ST_WAIT_PLL;
          end else if (w_sw_rst) begin
            // Debug reset stays released
            o_sys_nrst    <= 1'b0;
            o_rst_event   <= 1'b1;
            o_timer_start <= 1'b1;
            r_state       <= prci_cfg_pkg::ST_HOLD;
          end else if (!i_locks.ddr_locked) begin
            // No new hold, the system side returns once DDR does
            o_sys_nrst  <= 1'b0;
            o_rst_event <= 1'b1;
            r_state     <= prci_cfg_pkg::ST_HOLD;
          end
        end

        default: begin
          r_state <= prci_cfg_pkg::ST_RESET;
        end
      endcase
    end
  end

  assign o_state = r_state;

endmodule

// ==== hw/prci_apb_regs.sv ====
// Reset controller APB registers
`timescale 1ns/1ps

module prci_apb_regs (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  prci_bus_pkg::apb_in_t      i_apbi,
  output prci_bus_pkg::apb_out_t     o_apbo,
  input  prci_cfg_pkg::lock_status_t i_locks,
  input  prci_cfg_pkg::seq_state_t   i_state,
  input  logic                       i_rst_event,
  output logic                       o_soft_rst
);

  logic w_access;
  logic w_write;
  logic w_wr_ctrl;
  logic w_wr_rstcnt;
  logic w_mapped;

  prci_bus_pkg::apb_data_t w_rdata;
  prci_cfg_pkg::rst_cnt_t  r_rst_cnt;

  // Access phase of a transfer, always completed in one cycle
  assign w_access = i_apbi.psel && i_apbi.penable;
  assign w_write  = w_access && i_apbi.pwrite;

  assign w_wr_ctrl   = w_write && (i_apbi.paddr == prci_cfg_pkg::ADDR_CTRL);
  assign w_wr_rstcnt = w_write && (i_apbi.paddr == prci_cfg_pkg::ADDR_RSTCNT);

  // Soft reset request, one cycle after the access phase
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_soft_rst <= 1'b0;
    end else begin
      o_soft_rst <= w_wr_ctrl && i_apbi.pwdata[0];
    end
  end

  // Reset event counter, cleared by any write
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_rst_cnt <= '0;
    end else if (w_wr_rstcnt) begin
      r_rst_cnt <= '0;
    end else if (i_rst_event && (r_rst_cnt != '1)) begin
      r_rst_cnt <= r_rst_cnt + 1'b1;
    end
  end

  // Read mux
  always_comb begin
    w_rdata  = '0;
    w_mapped = 1'b1;
    case (i_apbi.paddr)
      prci_cfg_pkg::ADDR_STATUS: begin
        w_rdata = {28'd0, i_state, i_locks};
      end
      prci_cfg_pkg::ADDR_CTRL: begin
        // Write-only request bit
        w_rdata = '0;
      end
      prci_cfg_pkg::ADDR_RSTCNT: begin
        w_rdata = {16'd0, r_rst_cnt};
      end
      default: begin
        w_mapped = 1'b0;
      end
    endcase
  end

  assign o_apbo.prdata  = w_rdata;
  assign o_apbo.pslverr = w_access && !w_mapped;

endmodule

// ==== hw/prci_top.sv ====
// Power, reset and clock-status controller
`timescale 1ns/1ps

module prci_top #(
  parameter int FILTER_CYCLES = 4,
  parameter int HOLD_CYCLES   = 8
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_sys_locked,
  input  logic                   i_ddr_locked,
  input  logic                   i_dmireset,
  input  prci_bus_pkg::apb_in_t  i_apbi,
  output prci_bus_pkg::apb_out_t o_apbo,
  output logic                   o_sys_nrst,
  output logic                   o_dbg_nrst
);

  prci_cfg_pkg::lock_status_t w_locks;
  prci_cfg_pkg::seq_state_t   w_state;

  logic w_soft_rst;
  logic w_timer_start;
  logic w_timer_done;
  logic w_rst_event;

  // PLL lock and DDR calibration inputs
  prci_lock_filter #(
    .FILTER_CYCLES(FILTER_CYCLES)
  ) u_lock_filter (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_sys_locked(i_sys_locked),
    .i_ddr_locked(i_ddr_locked),
    .o_locks     (w_locks)
  );

  prci_hold_timer #(
    .HOLD_CYCLES(HOLD_CYCLES)
  ) u_hold_timer (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_start(w_timer_start),
    .o_done (w_timer_done)
  );

  prci_reset_seq u_reset_seq (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_locks      (w_locks),
    .i_timer_done (w_timer_done),
    .i_soft_rst   (w_soft_rst),
    .i_dmireset   (i_dmireset),
    .o_timer_start(w_timer_start),
    .o_rst_event  (w_rst_event),
    .o_state      (w_state),
    .o_sys_nrst   (o_sys_nrst),
    .o_dbg_nrst   (o_dbg_nrst)
  );

  // Status and control on the SoC APB bus
  prci_apb_regs u_apb_regs (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_apbi     (i_apbi),
    .o_apbo     (o_apbo),
    .i_locks    (w_locks),
    .i_state    (w_state),
    .i_rst_event(w_rst_event),
    .o_soft_rst (w_soft_rst)
  );

endmodule

// ==== tests/prci_assertions.sv ====
// Reset sequencer assertions
`timescale 1ns/1ps

module prci_assertions (
  input logic                       i_clk,
  input logic                       i_rst_n,
  input prci_cfg_pkg::lock_status_t i_locks,
  input logic                       i_timer_start,
  input logic                       i_sys_nrst,
  input logic                       i_dbg_nrst
);

  // Sticky failure flags, one per assertion
  bit r_fail_order;
  bit r_fail_ddr;
  bit r_fail_pulse;

  // System side is never out of reset while the debug side is held
  a_reset_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_sys_nrst |-> i_dbg_nrst)
    else begin
      r_fail_order = 1'b1;
      $error("o_sys_nrst high while o_dbg_nrst is low");
    end

  // Without DDR calibration the system reset is low by the next cycle
  a_ddr_gate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_locks.ddr_locked |=> !i_sys_nrst)
    else begin
      r_fail_ddr = 1'b1;
      $error("o_sys_nrst high without a filtered DDR lock");
    end

  a_start_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_timer_start |=> !i_timer_start)
    else begin
      r_fail_pulse = 1'b1;
      $error("o_timer_start held for more than one cycle");
    end

endmodule

bind prci_reset_seq prci_assertions u_assertions (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_locks      (i_locks),
  .i_timer_start(o_timer_start),
  .i_sys_nrst   (o_sys_nrst),
  .i_dbg_nrst   (o_dbg_nrst)
);

// ==== tests/prci_tb.sv ====
// Reset controller testbench
`timescale 1ns/1ps

module prci_tb;

  localparam int FILTER_CYCLES = 4;
  localparam int HOLD_CYCLES   = 8;
  localparam int CLK_PERIOD    = 100;
  localparam int SEL_SYS       = 0;
  localparam int SEL_DBG       = 1;

  // Worst-case cycle counts of the tests
  localparam int APB_CYCLES   = 3;
  localparam int PWRUP_CYCLES = 2 + FILTER_CYCLES + 1 + HOLD_CYCLES + 1;
  localparam int DDR_CYCLES   = 2 + FILTER_CYCLES + 3;
  localparam int SOFT_CYCLES  = 4 + HOLD_CYCLES + 4;
  localparam int T1_CYCLES    = 2 + 2 * APB_CYCLES;
  localparam int T3_CYCLES    = 4 * (3 + 4) + 4 + APB_CYCLES;
  localparam int T2_CYCLES    = PWRUP_CYCLES + 5 + DDR_CYCLES + APB_CYCLES;
  localparam int T4_CYCLES    = 2 * (APB_CYCLES + 1 + SOFT_CYCLES + APB_CYCLES);
  localparam int T5_CYCLES    = 4 + PWRUP_CYCLES + 1 + 3 * APB_CYCLES;
  localparam int WATCHDOG_CYCLES =
    2 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES);

  localparam prci_bus_pkg::apb_addr_t ADDR_UNMAPPED = 8'h0C;
  localparam prci_cfg_pkg::lock_status_t NO_LOCKS = '0;
  localparam prci_cfg_pkg::lock_status_t BOTH_LOCKS = '{sys_locked: 1'b1, ddr_locked: 1'b1};

  logic clk;
  logic rst_n;
  logic sys_locked;
  logic ddr_locked;
  logic dmireset;
  logic sys_nrst;
  logic dbg_nrst;
  logic [7:0] lfsr_state;

  prci_bus_pkg::apb_in_t  apbi;
  prci_bus_pkg::apb_out_t apbo;

  prci_top #(
    .FILTER_CYCLES(FILTER_CYCLES),
    .HOLD_CYCLES  (HOLD_CYCLES)
  ) dut0 (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_sys_locked(sys_locked),
    .i_ddr_locked(ddr_locked),
    .i_dmireset  (dmireset),
    .i_apbi      (apbi),
    .o_apbo      (apbo),
    .o_sys_nrst  (sys_nrst),
    .o_dbg_nrst  (dbg_nrst)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("Watchdog expired before the tests completed");
  end

  function automatic logic assertions_clean();
    return !(dut0.u_reset_seq.u_assertions.r_fail_order ||
             dut0.u_reset_seq.u_assertions.r_fail_ddr ||
             dut0.u_reset_seq.u_assertions.r_fail_pulse);
  endfunction

  always @(negedge clk) begin
    if (!assertions_clean()) begin
      report_failure("An assertion on the reset sequencer failed");
    end
  end

  // 8-bit Fibonacci LFSR with taps 8 6 5 4, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
    lfsr_state = {lfsr_state[6:0], fb};
    return fb;
  endfunction

  function automatic int glitch_width();
    logic [1:0] bits;
    bits[0] = lfsr_bit();
    bits[1] = lfsr_bit();
    return 1 + int'(bits) % 3;
  endfunction

  // STATUS holds the locks in bits 1:0 and the state in bits 3:2
  function automatic prci_bus_pkg::apb_data_t status_word(
    input prci_cfg_pkg::lock_status_t locks,
    input prci_cfg_pkg::seq_state_t   state
  );
    prci_bus_pkg::apb_data_t word;
    word      = '0;
    word[1]   = locks.sys_locked;
    word[0]   = locks.ddr_locked;
    word[3:2] = state;
    return word;
  endfunction

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR %0d ns %s: got %b, expected %b", $time, name, act, exp));
    end
  endtask

  task automatic check_data(input string name, input prci_bus_pkg::apb_data_t act,
                            input prci_bus_pkg::apb_data_t exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR %0d ns %s: got %h, expected %h", $time, name, act, exp));
    end
  endtask

  task automatic check_status(input string name, input prci_cfg_pkg::lock_status_t act,
                              input prci_cfg_pkg::lock_status_t exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR %0d ns %s: got %b, expected %b", $time, name, act, exp));
    end
  endtask

  task automatic check_count(input string name, input prci_cfg_pkg::rst_cnt_t act,
                             input prci_cfg_pkg::rst_cnt_t exp);
    if (act !== exp) begin
      report_failure($sformatf("ERROR %0d ns %s: got %0d, expected %0d", $time, name, act, exp));
    end
  endtask

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic apb_write(input prci_bus_pkg::apb_addr_t addr,
                           input prci_bus_pkg::apb_data_t data);
    apbi.psel    = 1'b1;
    apbi.penable = 1'b0;
    apbi.pwrite  = 1'b1;
    apbi.paddr   = addr;
    apbi.pwdata  = data;
    next_cycle();
    apbi.penable = 1'b1;
    next_cycle();
    apbi.psel    = 1'b0;
    apbi.penable = 1'b0;
  endtask

  task automatic apb_read(input prci_bus_pkg::apb_addr_t addr,
                          output prci_bus_pkg::apb_data_t data, output logic err);
    apbi.psel    = 1'b1;
    apbi.penable = 1'b0;
    apbi.pwrite  = 1'b0;
    apbi.paddr   = addr;
    apbi.pwdata  = '0;
    next_cycle();
    apbi.penable = 1'b1;
    // Sample mid access cycle
    #30;
    data = apbo.prdata;
    err  = apbo.pslverr;
    next_cycle();
    apbi.psel    = 1'b0;
    apbi.penable = 1'b0;
  endtask

  function automatic logic reset_level(input int sel);
    return (sel == SEL_SYS) ? sys_nrst : dbg_nrst;
  endfunction

  task automatic wait_reset(input string name, input int sel, input logic level,
                            input int max_cycles);
    int n;
    n = 0;
    while (reset_level(sel) !== level) begin
      if (n == max_cycles) begin
        report_failure($sformatf("%s did not go to %b within %0d cycles", name, level, n));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic read_rstcnt(input prci_cfg_pkg::rst_cnt_t exp);
    prci_bus_pkg::apb_data_t data;
    logic err;
    apb_read(prci_cfg_pkg::ADDR_RSTCNT, data, err);
    check_bit("pslverr", err, 1'b0);
    check_count("RSTCNT", data[15:0], exp);
  endtask

  // Raises the PLL lock and checks the exact debug reset release cycle
  task automatic power_up_dbg();
    sys_locked = 1'b1;
    next_cycle();
    for (int k = 1; k <= PWRUP_CYCLES; k++) begin
      next_cycle();
      check_bit("o_dbg_nrst", dbg_nrst, (k == PWRUP_CYCLES));
      if (k < PWRUP_CYCLES) begin
        check_bit("o_sys_nrst", sys_nrst, 1'b0);
      end
    end
  endtask

  // System reset drops, debug reset holds, then the hold time runs out
  task automatic soft_reset_hold();
    int low;
    wait_reset("o_sys_nrst", SEL_SYS, 1'b0, 4);
    low = 0;
    while (sys_nrst !== 1'b1) begin
      check_bit("o_dbg_nrst", dbg_nrst, 1'b1);
      if (low > HOLD_CYCLES + 4) begin
        report_failure("o_sys_nrst stayed low too long after a soft reset");
      end
      next_cycle();
      low++;
    end
    if (low < HOLD_CYCLES) begin
      report_failure("o_sys_nrst came back before the hold time ran out");
    end
  endtask

  task automatic test_after_reset();
    prci_bus_pkg::apb_data_t data;
    logic err;
    check_bit("o_sys_nrst", sys_nrst, 1'b0);
    check_bit("o_dbg_nrst", dbg_nrst, 1'b0);
    apb_read(prci_cfg_pkg::ADDR_STATUS, data, err);
    check_bit("pslverr", err, 1'b0);
    check_data("STATUS", data, status_word(NO_LOCKS, prci_cfg_pkg::ST_WAIT_PLL));
    apb_read(ADDR_UNMAPPED, data, err);
    check_bit("pslverr", err, 1'b1);
    check_data("prdata", data, '0);
  endtask

  task automatic test_lock_glitches();
    prci_bus_pkg::apb_data_t data;
    logic err;
    int width;
    for (int i = 0; i < 4; i++) begin
      width = glitch_width();
      sys_locked = 1'b1;
      for (int c = 0; c < width + 4; c++) begin
        next_cycle();
        if (c == width - 1) begin
          sys_locked = 1'b0;
        end
        check_bit("o_sys_nrst", sys_nrst, 1'b0);
        check_bit("o_dbg_nrst", dbg_nrst, 1'b0);
        check_status("w_locks", dut0.w_locks, NO_LOCKS);
      end
    end
    apb_read(prci_cfg_pkg::ADDR_STATUS, data, err);
    check_status("STATUS locks", data[1:0], NO_LOCKS);
  endtask

  task automatic test_power_up();
    prci_bus_pkg::apb_data_t data;
    logic err;
    power_up_dbg();
    repeat (4) begin
      next_cycle();
      check_bit("o_sys_nrst", sys_nrst, 1'b0);
    end
    ddr_locked = 1'b1;
    wait_reset("o_sys_nrst", SEL_SYS, 1'b1, DDR_CYCLES);
    apb_read(prci_cfg_pkg::ADDR_STATUS, data, err);
    check_status("STATUS locks", data[1:0], BOTH_LOCKS);
    check_data("STATUS", data, status_word(BOTH_LOCKS, prci_cfg_pkg::ST_RUN));
  endtask

  task automatic test_soft_reset();
    apb_write(prci_cfg_pkg::ADDR_CTRL, 32'd1);
    soft_reset_hold();
    read_rstcnt(16'd1);
    dmireset = 1'b1;
    next_cycle();
    dmireset = 1'b0;
    soft_reset_hold();
    read_rstcnt(16'd2);
  endtask

  task automatic test_lock_loss();
    sys_locked = 1'b0;
    wait_reset("o_dbg_nrst", SEL_DBG, 1'b0, 4);
    check_bit("o_sys_nrst", sys_nrst, 1'b0);
    read_rstcnt(16'd3);
    power_up_dbg();
    check_bit("o_sys_nrst", sys_nrst, 1'b1);
    apb_write(prci_cfg_pkg::ADDR_RSTCNT, 32'd0);
    read_rstcnt(16'd0);
  endtask

  initial begin
    rst_n      = 1'b0;
    sys_locked = 1'b0;
    ddr_locked = 1'b0;
    dmireset   = 1'b0;
    apbi       = '0;
    lfsr_state = 8'd25;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_after_reset();
    test_lock_glitches();
    test_power_up();
    test_soft_reset();
    test_lock_loss();
    if (assertions_clean()) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("An assertion on the reset sequencer failed");
    end
  end

endmodule

// ==== flist.f ====
hw/prci_bus_pkg.sv
hw/prci_cfg_pkg.sv
hw/prci_lock_filter.sv
hw/prci_hold_timer.sv
hw/prci_reset_seq.sv
hw/prci_apb_regs.sv
hw/prci_top.sv
tests/prci_assertions.sv
tests/prci_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module prci_tb -f flist.f -o prci_sim

out="$(./obj_dir/prci_sim 2>&1 || true)"
printf '%s\n' "$out"

# The run passed only if the pass message was printed
printf '%s\n' "$out" | grep -qF '=== PASS ==='
